// ==== verilog/proc_cfg.svh ====
// widths, reset values, trigger point limits and firmware version of the command processor
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// sample memory
`define RAM_WIDTH 12 // sample address width, 4096 samples
`define TRIG_PT_MIN 4 // lowest trigger point accepted by code 121
`define TRIG_PT_MAX 4080 // highest trigger point, leaves 16 samples of margin

// command framing
`define MAX_ARGS 2 // most argument bytes any kept opcode takes

// replies
`define FW_VERSION 8'd18 // answered to code 147

// reset values
`define ID_RESET 8'd200 // no id assigned yet
`define TRIG_PT_RESET 1024 // a quarter of the sample memory
`define THRESH_RESET 8'h80 // mid scale
`define THRESH_HI_RESET 8'hff // high threshold fully open
`define TYPE_RESET 4'b0001 // rising edge only
`define CHAN_EN_RESET 4'b1111 // all four channels may trigger

`endif

// ==== verilog/chain_pkg.sv ====
// chain command codes, received byte event and decoded command types
`include "proc_cfg.svh"

package chain_pkg;

	typedef enum logic [7:0] {
		CMD_ID_BASE = 8'd0, // 0-9 assign board id
		CMD_LAST_BASE = 8'd20, // 20-29 mark the last board
		CMD_ACTIVE_BASE = 8'd30, // 30-39 pick the active board
		CMD_SET_ID = 8'd50, // id in the argument byte
		CMD_ROLL_ON = 8'd101,
		CMD_ROLL_OFF = 8'd102,
		CMD_TRIG_PT = 8'd121, // two bytes, high first
		CMD_NSMP = 8'd122, // samples to send, two bytes
		CMD_THRESH = 8'd127,
		CMD_TRIG_TYPE = 8'd128,
		CMD_CHAN_TOG = 8'd130, // argument is board*4+channel
		CMD_THRESH_HI = 8'd140,
		CMD_CHIP_ID = 8'd142, // reply with 8 bytes
		CMD_VERSION = 8'd147 // reply with 1 byte
	} cmd_code_e;

	typedef logic [$clog2(`MAX_ARGS + 1)-1:0] arg_cnt_t; // 0 .. MAX_ARGS

	typedef struct packed {
		logic [7:0] data; // byte as received
		logic is_op; // first byte of a command
		logic is_arg; // argument byte
		arg_cnt_t arg_idx; // argument position, 0 for opcodes
	} byte_event_t;

	typedef struct packed {
		logic [7:0] op;
		logic [7:0] arg0; // first argument, high byte of 16-bit values
		logic [7:0] arg1;
	} cmd_t;

endpackage

// ==== verilog/trigger_pkg.sv ====
// trigger configuration type shared by the settings block and the top level
`include "proc_cfg.svh"

package trigger_pkg;

	// complete trigger setup of one board
	typedef struct packed {
		logic [7:0] thresh; // trigger level
		logic [7:0] thresh_hi; // signal must stay below this
		logic [3:0] trig_type; // bit 0 rising, bit 1 falling, others spare
		logic [3:0] chan_en; // one enable per channel of this board
		logic [`RAM_WIDTH-1:0] trig_pt; // samples kept before the trigger
		logic [`RAM_WIDTH-1:0] nsmp; // samples to send, 0 sends the full memory
		logic rolling; // free running capture
	} trig_cfg_t;

endpackage

// ==== verilog/cmd_parser.sv ====
// command parser: tags opcode and argument bytes and emits completed commands
`timescale 1ns/100ps

module cmd_parser
	import chain_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic rxReady,
	input logic [7:0] rxData,
	input logic reply_busy,
	output logic evt_valid,
	output byte_event_t byte_evt,
	output logic cmd_valid,
	output cmd_t cmd
);

	logic in_cmd; // opcode held, arguments pending
	logic [7:0] op_reg; // opcode of the command being collected
	arg_cnt_t need; // argument bytes op_reg takes
	arg_cnt_t arg_cnt; // argument bytes in so far
	logic [7:0] arg_first; // first argument, kept for two-byte commands
	logic take; // byte accepted this cycle
	arg_cnt_t rx_need; // argument count of rxData as an opcode

	// argument bytes per opcode, unknown codes take none
	function automatic arg_cnt_t args_needed(logic [7:0] op);
		case (op)
			CMD_SET_ID, CMD_THRESH, CMD_TRIG_TYPE, CMD_CHAN_TOG,
			CMD_THRESH_HI: return arg_cnt_t'(1);
			CMD_TRIG_PT, CMD_NSMP: return arg_cnt_t'(2);
			default: return '0;
		endcase
	endfunction

	assign take = rxReady && !reply_busy; // bytes during a reply are dropped
	assign rx_need = args_needed(rxData);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_cmd <= 1'b0;
			op_reg <= '0;
			need <= '0;
			arg_cnt <= '0;
			evt_valid <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			evt_valid <= take;
			cmd_valid <= 1'b0;
			if (take && !in_cmd) begin // opcode byte
				op_reg <= rxData;
				need <= rx_need;
				arg_cnt <= '0;
				in_cmd <= (rx_need != '0);
				cmd_valid <= (rx_need == '0); // complete at once
			end else if (take) begin // argument byte
				arg_cnt <= arg_cnt + 1'b1;
				if (arg_cnt + 1'b1 == need) begin
					in_cmd <= 1'b0;
					cmd_valid <= 1'b1; // last argument in
				end
			end
		end
	end

	// byte and command payload, qualified by the strobes above
	always_ff @(posedge clk) begin
		if (take) begin
			byte_evt.data <= rxData;
			byte_evt.is_op <= !in_cmd;
			byte_evt.is_arg <= in_cmd;
			byte_evt.arg_idx <= in_cmd ? arg_cnt : '0;
			if (!in_cmd) begin
				cmd <= '{op: rxData, arg0: 8'h00, arg1: 8'h00};
			end else if (arg_cnt == '0) begin
				arg_first <= rxData;
				cmd <= '{op: op_reg, arg0: rxData, arg1: 8'h00};
			end else begin
				cmd <= '{op: op_reg, arg0: arg_first, arg1: rxData};
			end
		end
	end

endmodule

// ==== verilog/chain_control.sv ====
// chain control: board id, master clock, last flag, passthrough and byte forwarding
`timescale 1ns/100ps
`include "proc_cfg.svh"

module chain_control
	import chain_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic evt_valid,
	input byte_event_t byte_evt,
	input logic cmd_valid,
	input cmd_t cmd,
	output logic [7:0] my_id,
	output logic [1:0] master_clock,
	output logic imthelast,
	output logic imthefirst,
	output logic passthrough,
	output logic [7:0] comdata,
	output logic newcomdata
);

	logic [7:0] cur_op; // opcode of the command whose arguments arrive
	logic [7:0] evt_op; // opcode that the current byte belongs to
	logic is_id_code; // byte is 0-9
	logic is_active_code; // byte is 30-39
	logic active_mine; // active code naming this board
	logic local_query; // 142 or 147 answered here
	logic fwd; // byte goes down the chain
	logic [7:0] fwd_data; // byte as forwarded
	logic [7:0] new_id; // id carried by an id command

	assign evt_op = byte_evt.is_op ? byte_evt.data : cur_op;
	assign is_id_code = (byte_evt.data <= 8'd9);
	assign is_active_code = (byte_evt.data >= 8'd30) && (byte_evt.data <= 8'd39);
	assign active_mine = is_active_code && ((byte_evt.data - 8'd30) == my_id);
	assign local_query = !passthrough
		&& (byte_evt.data == CMD_CHIP_ID || byte_evt.data == CMD_VERSION);

	always_comb begin
		fwd = 1'b1;
		fwd_data = byte_evt.data;
		if (byte_evt.is_op) begin
			if (local_query || active_mine)
				fwd = 1'b0; // kept on this board
			else if (is_id_code)
				fwd_data = byte_evt.data + 8'd1; // next board gets the next id
		end else if (evt_op == CMD_SET_ID) begin
			fwd_data = byte_evt.data + 8'd1;
		end
	end

	assign new_id = (cmd.op == CMD_SET_ID) ? cmd.arg0 : cmd.op;
	assign imthefirst = (my_id == 8'd0);

	// forwarding, one pulse per passed byte
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cur_op <= '0;
			comdata <= '0;
			newcomdata <= 1'b0;
		end else begin
			newcomdata <= 1'b0;
			if (evt_valid) begin
				if (byte_evt.is_op)
					cur_op <= byte_evt.data;
				if (fwd) begin
					comdata <= fwd_data;
					newcomdata <= 1'b1;
				end
			end
		end
	end

	// board state, updated on completed commands
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			my_id <= `ID_RESET;
			master_clock <= 2'b00;
			imthelast <= 1'b0;
			passthrough <= 1'b0;
		end else if (cmd_valid) begin
			if (cmd.op <= 8'd9 || cmd.op == CMD_SET_ID) begin
				my_id <= new_id;
				master_clock <= (new_id == 8'd0) ? 2'b00 : 2'b01; // board 0 drives the clock
			end else if (cmd.op >= 8'd20 && cmd.op <= 8'd29) begin
				imthelast <= ((cmd.op - 8'd20) == my_id);
			end else if (cmd.op >= 8'd30 && cmd.op <= 8'd39) begin
				passthrough <= ((cmd.op - 8'd30) != my_id);
			end
		end
	end

endmodule

// ==== verilog/trigger_settings.sv ====
// trigger setting registers: thresholds, type, trigger point clamp, sample count, channel toggles
`timescale 1ns/100ps
`include "proc_cfg.svh"

module trigger_settings
	import chain_pkg::*;
	import trigger_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input cmd_t cmd,
	input logic [7:0] my_id,
	output trig_cfg_t trig_cfg
);

	localparam int PW = `RAM_WIDTH + 1; // room for trigger point plus margin

	logic [15:0] arg_word; // arg0 high byte, arg1 low byte
	logic [`RAM_WIDTH-1:0] pt_clamped; // code 121 value inside the limits
	logic [`RAM_WIDTH-1:0] nsmp_new; // code 122 sample count
	logic [PW-1:0] pt_end; // trigger point plus 5 samples
	logic pt_too_late; // trigger point past the new sample count
	logic [1:0] chan_sel; // channel number on the addressed board
	logic chan_mine; // toggle addressed to this board

	assign arg_word = {cmd.arg0, cmd.arg1};

	always_comb begin
		if (arg_word > 16'(`TRIG_PT_MAX))
			pt_clamped = `RAM_WIDTH'(`TRIG_PT_MAX);
		else if (arg_word < 16'(`TRIG_PT_MIN))
			pt_clamped = `RAM_WIDTH'(`TRIG_PT_MIN);
		else
			pt_clamped = arg_word[`RAM_WIDTH-1:0];
	end

	assign nsmp_new = arg_word[`RAM_WIDTH-1:0];
	assign pt_end = {1'b0, trig_cfg.trig_pt} + PW'(5);
	assign pt_too_late = pt_end > {1'b0, nsmp_new};
	assign chan_sel = cmd.arg0[1:0]; // arg mod 4
	assign chan_mine = ({2'b00, cmd.arg0[7:2]} == my_id); // arg div 4

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			trig_cfg <= '{thresh: `THRESH_RESET, thresh_hi: `THRESH_HI_RESET,
				trig_type: `TYPE_RESET, chan_en: `CHAN_EN_RESET,
				trig_pt: `RAM_WIDTH'(`TRIG_PT_RESET), nsmp: '0, rolling: 1'b1};
		end else if (cmd_valid) begin
			case (cmd.op)
				CMD_TRIG_PT: trig_cfg.trig_pt <= pt_clamped;
				CMD_NSMP: begin
					trig_cfg.nsmp <= nsmp_new;
					if (pt_too_late)
						trig_cfg.trig_pt <= nsmp_new >> 1; // center it instead
				end
				CMD_THRESH: trig_cfg.thresh <= cmd.arg0;
				CMD_THRESH_HI: trig_cfg.thresh_hi <= cmd.arg0;
				CMD_TRIG_TYPE: trig_cfg.trig_type <= cmd.arg0[3:0];
				CMD_ROLL_ON: trig_cfg.rolling <= 1'b1;
				CMD_ROLL_OFF: trig_cfg.rolling <= 1'b0;
				CMD_CHAN_TOG: begin
					if (chan_mine)
						trig_cfg.chan_en[chan_sel] <= ~trig_cfg.chan_en[chan_sel];
				end
				default: ; // other commands leave the trigger alone
			endcase
		end
	end

endmodule

// ==== verilog/reply_sender.sv ====
// reply sender: firmware version and chip id bytes to the serial transmitter
`timescale 1ns/100ps
`include "proc_cfg.svh"

module reply_sender
	import chain_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input cmd_t cmd,
	input logic passthrough,
	input logic txBusy,
	input logic [63:0] chip_id,
	output logic txStart,
	output logic [7:0] txData,
	output logic reply_busy
);

	typedef enum logic [1:0] {
		S_IDLE, // waiting for a local query
		S_SEND, // start a byte once the transmitter is free
		S_GAP // one cycle after each start
	} state_e;

	state_e state;
	logic [63:0] reply_data; // remaining bytes, next one in the low byte
	logic [2:0] bytes_left; // bytes after the current one
	logic accept; // query answered by this board

	assign accept = cmd_valid && !passthrough
		&& (cmd.op == CMD_CHIP_ID || cmd.op == CMD_VERSION);
	assign txStart = (state == S_SEND) && !txBusy;
	assign txData = reply_data[7:0];
	assign reply_busy = (state != S_IDLE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			bytes_left <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_SEND;
						bytes_left <= (cmd.op == CMD_CHIP_ID) ? 3'd7 : 3'd0;
					end
				end
				S_SEND: if (!txBusy) state <= S_GAP; // start goes out this cycle
				S_GAP: begin
					if (bytes_left == '0) begin
						state <= S_IDLE; // last byte gone
					end else begin
						state <= S_SEND;
						bytes_left <= bytes_left - 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// reply bytes, chip id least significant byte first
	always_ff @(posedge clk) begin
		if (state == S_IDLE && accept)
			reply_data <= (cmd.op == CMD_CHIP_ID) ? chip_id : {56'd0, `FW_VERSION};
		else if (txStart)
			reply_data <= {8'd0, reply_data[63:8]};
	end

endmodule

// ==== verilog/scope_processor.sv ====
// command processor top level: parser, chain control, trigger settings and reply sender
`timescale 1ns/100ps

module scope_processor
	import chain_pkg::*;
	import trigger_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic rxReady,
	input logic [7:0] rxData,
	input logic txBusy,
	input logic [63:0] chip_id,
	output logic txStart,
	output logic [7:0] txData,
	output logic [7:0] comdata,
	output logic newcomdata,
	output logic [7:0] my_id,
	output logic [1:0] master_clock,
	output logic imthelast,
	output logic imthefirst,
	output logic passthrough,
	output trig_cfg_t trig_cfg
);

	logic evt_valid; // one strobe per accepted byte
	byte_event_t byte_evt;
	logic cmd_valid; // one strobe per completed command
	cmd_t cmd;
	logic reply_busy; // reply in progress, input bytes dropped

	cmd_parser cmd_parser_inst (
		.clk(clk), .arst_n(arst_n), .rxReady(rxReady), .rxData(rxData),
		.reply_busy(reply_busy), .evt_valid(evt_valid), .byte_evt(byte_evt),
		.cmd_valid(cmd_valid), .cmd(cmd)
	);

	chain_control chain_control_inst (
		.clk(clk), .arst_n(arst_n), .evt_valid(evt_valid), .byte_evt(byte_evt),
		.cmd_valid(cmd_valid), .cmd(cmd), .my_id(my_id), .master_clock(master_clock),
		.imthelast(imthelast), .imthefirst(imthefirst), .passthrough(passthrough),
		.comdata(comdata), .newcomdata(newcomdata)
	);

	trigger_settings trigger_settings_inst (
		.clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.my_id(my_id), .trig_cfg(trig_cfg)
	);

	reply_sender reply_sender_inst (
		.clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.passthrough(passthrough), .txBusy(txBusy), .chip_id(chip_id),
		.txStart(txStart), .txData(txData), .reply_busy(reply_busy)
	);

endmodule

// ==== test/scope_processor_properties.sv ====
// concurrent checks on transmitter start, chain strobe and reply end of the top level
`timescale 1ns/100ps

module scope_processor_properties (
	input logic clk,
	input logic arst_n,
	input logic txStart,
	input logic txBusy,
	input logic newcomdata,
	input logic reply_busy
);

	start_when_free: assert property (@(posedge clk) disable iff (!arst_n)
		txStart |-> !txBusy) else $error("txStart raised while transmitter busy");

	single_start: assert property (@(posedge clk) disable iff (!arst_n)
		txStart |=> !txStart) else $error("txStart high on two cycles in a row");

	single_forward: assert property (@(posedge clk) disable iff (!arst_n)
		newcomdata |=> !newcomdata) else $error("newcomdata high on two cycles in a row");

	// start, one gap cycle, then idle
	reply_ends_after_start: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(reply_busy) |-> $past(txStart, 2)) else $error("reply ended without a start");

endmodule

bind scope_processor scope_processor_properties scope_processor_properties_inst (
	.clk(clk), .arst_n(arst_n), .txStart(txStart), .txBusy(txBusy),
	.newcomdata(newcomdata), .reply_busy(reply_busy)
);

// ==== test/tb_top.sv ====
// testbench top: clock, reset, pattern replay, transmitter model, checks and watchdog
`timescale 1ns/100ps

module tb_top
	import trigger_pkg::*;
();

	localparam logic [63:0] CHIP_ID = 64'h0123_4567_89ab_cdef; // static board chip id
	localparam int MAX_TESTS = 40;

	logic clk;
	logic arst_n;
	logic rxReady;
	logic [7:0] rxData;
	logic txBusy;
	logic txStart;
	logic [7:0] txData;
	logic [7:0] comdata;
	logic newcomdata;
	logic [7:0] my_id;
	logic [1:0] master_clock;
	logic imthelast;
	logic imthefirst;
	logic passthrough;
	trig_cfg_t trig_cfg;

	string names[MAX_TESTS]; // one entry per pattern line
	string fields[MAX_TESTS]; // output checked after the bytes
	int nbytes[MAX_TESTS];
	int nfwd[MAX_TESTS];
	int ntx[MAX_TESTS];
	logic [7:0] rx_bytes[MAX_TESTS][4];
	logic [7:0] fwd_bytes[MAX_TESTS][4];
	logic [31:0] exp_val[MAX_TESTS];
	int ntests = 0;
	int total_bytes = 0; // sizes the watchdog
	int errors = 0;
	int checks = 0;
	logic loaded = 1'b0;
	logic [7:0] fwd_q[$]; // every byte seen on comdata
	logic [7:0] tx_q[$]; // every byte handed to the transmitter
	logic [31:0] lfsr = 32'h28aa_2f76;

	scope_processor scope_processor_inst (
		.clk(clk), .arst_n(arst_n), .rxReady(rxReady), .rxData(rxData), .txBusy(txBusy),
		.chip_id(CHIP_ID), .txStart(txStart), .txData(txData), .comdata(comdata),
		.newcomdata(newcomdata), .my_id(my_id), .master_clock(master_clock),
		.imthelast(imthelast), .imthefirst(imthefirst), .passthrough(passthrough),
		.trig_cfg(trig_cfg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32,22,2,1
	endfunction

	// busy time of one transmitted byte, 2..9 cycles
	function automatic int busy_cycles();
		int n;
		n = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			n = (n << 1) | int'(lfsr[0]);
		end
		return 2 + n;
	endfunction

	// transmitter model, goes busy right after each accepted start
	initial begin
		txBusy = 1'b0;
		forever begin
			@(negedge clk);
			if (txStart) begin
				tx_q.push_back(txData);
				@(posedge clk);
				#1;
				txBusy = 1'b1;
				repeat (busy_cycles()) @(posedge clk);
				#1;
				txBusy = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (newcomdata)
			fwd_q.push_back(comdata); // chain output, sampled mid cycle
	end

	function automatic logic [31:0] field_value(string fl);
		case (fl)
			"myid": return 32'(my_id);
			"mclk": return 32'(master_clock);
			"first": return 32'(imthefirst);
			"last": return 32'(imthelast);
			"pass": return 32'(passthrough);
			"trigpt": return 32'(trig_cfg.trig_pt);
			"nsmp": return 32'(trig_cfg.nsmp);
			"thresh": return 32'(trig_cfg.thresh);
			"threshhi": return 32'(trig_cfg.thresh_hi);
			"ttype": return 32'(trig_cfg.trig_type);
			"chen": return 32'(trig_cfg.chan_en);
			"roll": return 32'(trig_cfg.rolling);
			default: begin
				$display("pattern names an unknown output %s", fl);
				return 32'hxxxx_xxxx;
			end
		endcase
	endfunction

	// reply byte i for a query opcode: version 18, or chip id low byte first
	function automatic logic [7:0] reply_byte(logic [7:0] op, int i);
		return (op == 8'd147) ? 8'd18 : CHIP_ID[8*i +: 8];
	endfunction

	task automatic check_value(string tname, string what, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", tname, what, exp, act);
			errors++;
		end
	endtask

	task automatic read_patterns();
		int fd;
		int n;
		int v[12];
		string line;
		string nm;
		string fl;
		fd = $fopen("test/processor_patterns.txt", "r");
		if (fd == 0) begin
			$display("pattern file test/processor_patterns.txt could not be opened");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue; // comment or blank line
			n = $sscanf(line, "%s %d %h %h %h %h %d %h %h %h %h %d %s %h", nm, v[0], v[1],
				v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], fl, v[11]);
			if (n != 14 || ntests == MAX_TESTS) begin
				$display("pattern line could not be read: %s", line);
				errors++;
				continue;
			end
			names[ntests] = nm;
			fields[ntests] = fl;
			nbytes[ntests] = v[0];
			nfwd[ntests] = v[5];
			ntx[ntests] = v[10];
			exp_val[ntests] = v[11];
			for (int i = 0; i < 4; i++) begin
				rx_bytes[ntests][i] = v[1+i];
				fwd_bytes[ntests][i] = v[6+i];
			end
			total_bytes += v[0];
			ntests++;
		end
		$fclose(fd);
	endtask

	task automatic send_byte(logic [7:0] b);
		@(posedge clk);
		#1;
		rxReady = 1'b1; // one cycle strobe
		rxData = b;
		@(posedge clk);
		#1;
		rxReady = 1'b0;
		repeat (6) @(posedge clk); // byte spacing
	endtask

	task automatic run_test(int t);
		int err0;
		int fbase;
		int tbase;
		err0 = errors;
		fbase = fwd_q.size();
		tbase = tx_q.size();
		for (int i = 0; i < nbytes[t]; i++)
			send_byte(rx_bytes[t][i]);
		if (ntx[t] > 0) begin
			while (tx_q.size() - tbase < ntx[t])
				@(negedge clk);
			while (scope_processor_inst.reply_busy)
				@(negedge clk); // reply done
		end
		check_value(names[t], "forwarded count", nfwd[t], fwd_q.size() - fbase);
		for (int i = 0; i < nfwd[t] && fbase + i < fwd_q.size(); i++)
			check_value(names[t], "forwarded byte", fwd_bytes[t][i], fwd_q[fbase+i]);
		check_value(names[t], "reply count", ntx[t], tx_q.size() - tbase);
		for (int i = 0; i < ntx[t] && tbase + i < tx_q.size(); i++)
			check_value(names[t], "reply byte", reply_byte(rx_bytes[t][0], i), tx_q[tbase+i]);
		check_value(names[t], fields[t], exp_val[t], field_value(fields[t]));
		$display("test %-12s %s", names[t], (errors == err0) ? "ok" : "has errors");
	endtask

	initial begin
		arst_n = 1'b0;
		rxReady = 1'b0;
		rxData = 8'h00;
		read_patterns();
		loaded = 1'b1;
		repeat (2) @(posedge clk); // reset for 2 cycles
		#1;
		arst_n = 1'b1;
		for (int t = 0; t < ntests; t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
		if (errors == 0 && ntests > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog, 200 cycles per pattern byte plus 2000
	initial begin
		wait (loaded);
		repeat (200 * total_bytes + 2000) @(posedge clk);
		$display("watchdog expired before all tests finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== test/processor_patterns.txt ====
# name nbytes b0 b1 b2 b3 nfwd f0 f1 f2 f3 ntx field value
# bytes and values in hex, counts in decimal, unused byte slots are 00
id3         1 03 00 00 00 1 04 00 00 00 0 myid 03
id3_clock   0 00 00 00 00 0 00 00 00 00 0 mclk 1
setid0      2 32 00 00 00 2 32 01 00 00 0 myid 00
first       0 00 00 00 00 0 00 00 00 00 0 first 1
id0_clock   0 00 00 00 00 0 00 00 00 00 0 mclk 0
last_set    1 14 00 00 00 1 14 00 00 00 0 last 1
last_clr    1 15 00 00 00 1 15 00 00 00 0 last 0
active_me   1 1e 00 00 00 0 00 00 00 00 0 pass 0
active_oth  1 1f 00 00 00 1 1f 00 00 00 0 pass 1
ver_pass    1 93 00 00 00 1 93 00 00 00 0 pass 1
active_back 1 1e 00 00 00 0 00 00 00 00 0 pass 0
trigpt_max  3 79 0f ff 00 3 79 0f ff 00 0 trigpt ff0
trigpt_min  3 79 00 01 00 3 79 00 01 00 0 trigpt 004
trigpt_1024 3 79 04 00 00 3 79 04 00 00 0 trigpt 400
nsmp        3 7a 00 64 00 3 7a 00 64 00 0 nsmp 064
nsmp_pt     0 00 00 00 00 0 00 00 00 00 0 trigpt 032
thresh      2 7f 55 00 00 2 7f 55 00 00 0 thresh 55
thresh_hi   2 8c a0 00 00 2 8c a0 00 00 0 threshhi a0
trig_type   2 80 f3 00 00 2 80 f3 00 00 0 ttype 3
roll_off    1 66 00 00 00 1 66 00 00 00 0 roll 0
roll_on     1 65 00 00 00 1 65 00 00 00 0 roll 1
chan_mine   2 82 02 00 00 2 82 02 00 00 0 chen b
chan_other  2 82 06 00 00 2 82 06 00 00 0 chen b
version     1 93 00 00 00 0 00 00 00 00 1 pass 0
chip_id     1 8e 00 00 00 0 00 00 00 00 8 pass 0

// ==== verilog.f ====
+incdir+verilog
verilog/chain_pkg.sv
verilog/trigger_pkg.sv
verilog/cmd_parser.sv
verilog/chain_control.sv
verilog/trigger_settings.sv
verilog/reply_sender.sv
verilog/scope_processor.sv
test/scope_processor_properties.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_top
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
